// File: design/img_capture_pkg.sv
package img_capture_pkg;

    // ============================================================
    // Word and pixel formats
    // ============================================================
    localparam int WORD_W  = 16;
    localparam int PIXEL_W = 12;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [PIXEL_W-1:0] pixel_t;

    // Header words, first word in the top bits
    localparam int HEADER_WORDS = 4;
    localparam int HDR_CNT_W    = $clog2(HEADER_WORDS);
    typedef logic [HEADER_WORDS*WORD_W-1:0] header_t;

    // Cycles the framer stays busy after eof so the trailer can drain
    localparam int END_HOLD = 3;

    // ============================================================
    // Output FIFO and statistics
    // ============================================================
    localparam int FIFO_DEPTH   = 32;
    localparam int FIFO_ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W   = FIFO_ADDR_W + 1;

    localparam int WORD_COUNT_W  = 16;
    localparam int STAT_COUNT_W  = 18;
    localparam int STAT_BITS     = 7;
    localparam int SAMPLE_GRID_W = 2;

    // Fletcher-32 modulus
    localparam logic [WORD_W:0] FLETCHER_MOD = 17'd65535;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_WAIT_FV_LOW,
        ST_WAIT_FV_HIGH,
        ST_FRAME,
        ST_END
    } framer_state_t;

    // Little-endian view of a stream word
    function automatic word_t swap_bytes(word_t w);
        return {w[7:0], w[15:8]};
    endfunction

endpackage

// File: design/word_stream_if.sv
`timescale 1ns/1ps

// One word beat between pipeline stages, no back-pressure
interface word_stream_if import img_capture_pkg::*; ();

    logic  valid;
    word_t data;
    logic  sample;
    logic  eof;

    modport src (
        output valid,
        output data,
        output sample,
        output eof
    );

    modport dst (
        input valid,
        input data,
        input sample,
        input eof
    );

endinterface

// File: design/pixel_framer.sv
`timescale 1ns/1ps

module pixel_framer import img_capture_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_capture,
    input  header_t       cmd_header,
    input  pixel_t        img_d,
    input  logic          img_fv,
    input  logic          img_lv,
    output logic          capture_start,
    word_stream_if.src    out
);

    pixel_t                   img_d_r;
    logic                     fv_r;
    logic                     lv_r;
    logic                     lv_prev;
    logic [SAMPLE_GRID_W-1:0] x_ph;
    logic [SAMPLE_GRID_W-1:0] y_ph;

    framer_state_t            state;
    header_t                  hdr_sr;
    logic [HDR_CNT_W-1:0]     cnt;

    pixel_t                   pix_s;
    logic                     pix_vld_s;
    logic                     pix_smp_s;
    logic                     eof_s;

    logic                     accept;
    logic                     in_frame;
    logic                     hdr_emit;
    word_t                    hdr_word;

    // ============================================================
    // Sensor input register and grid phase
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fv_r    <= 1'b0;
            lv_r    <= 1'b0;
            lv_prev <= 1'b0;
            x_ph    <= '0;
            y_ph    <= '0;
        end else begin
            fv_r    <= img_fv;
            lv_r    <= img_lv;
            lv_prev <= lv_r;
            if (!lv_r)
                x_ph <= '0;
            else
                x_ph <= x_ph + 1'b1;
            // Line count advances on the falling edge of line-valid
            if (!fv_r)
                y_ph <= '0;
            else if (lv_prev && !lv_r)
                y_ph <= y_ph + 1'b1;
        end
    end

    always_comb begin
        accept   = (state == ST_IDLE) && cmd_capture;
        in_frame = fv_r && (state == ST_FRAME || state == ST_WAIT_FV_HIGH);
        hdr_emit = accept || (state == ST_HEADER);
        if (accept)
            hdr_word = cmd_header[HEADER_WORDS*WORD_W-1 -: WORD_W];
        else
            hdr_word = hdr_sr[HEADER_WORDS*WORD_W-1 -: WORD_W];
    end

    // ============================================================
    // Capture FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // First header word goes out on this edge
                    if (cmd_capture) begin
                        cnt   <= HDR_CNT_W'(HEADER_WORDS - 1);
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == HDR_CNT_W'(1))
                        state <= ST_WAIT_FV_LOW;
                end
                ST_WAIT_FV_LOW: begin
                    if (!fv_r)
                        state <= ST_WAIT_FV_HIGH;
                end
                ST_WAIT_FV_HIGH: begin
                    if (fv_r)
                        state <= ST_FRAME;
                end
                ST_FRAME: begin
                    if (!fv_r) begin
                        cnt   <= HDR_CNT_W'(END_HOLD);
                        state <= ST_END;
                    end
                end
                ST_END: begin
                    if (cnt == '0)
                        state <= ST_IDLE;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Pixel stage and output beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_vld_s     <= 1'b0;
            pix_smp_s     <= 1'b0;
            eof_s         <= 1'b0;
            out.valid     <= 1'b0;
            out.sample    <= 1'b0;
            out.eof       <= 1'b0;
            capture_start <= 1'b0;
        end else begin
            pix_vld_s     <= in_frame && lv_r;
            pix_smp_s     <= in_frame && lv_r && (x_ph == '0) && (y_ph == '0);
            // Delayed by the stage so eof trails the last pixel word
            eof_s         <= (state == ST_FRAME) && !fv_r;
            out.valid     <= hdr_emit || pix_vld_s;
            out.sample    <= pix_smp_s;
            out.eof       <= eof_s;
            capture_start <= accept;
        end
    end

    always_ff @(posedge clk) begin
        img_d_r <= img_d;
        pix_s   <= img_d_r;
        if (accept)
            hdr_sr <= cmd_header << WORD_W;
        else if (state == ST_HEADER)
            hdr_sr <= hdr_sr << WORD_W;
        if (hdr_emit)
            out.data <= hdr_word;
        else
            out.data <= swap_bytes({{(WORD_W-PIXEL_W){1'b0}}, pix_s});
    end

endmodule

// File: design/fletcher_trailer.sv
`timescale 1ns/1ps

module fletcher_trailer import img_capture_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          capture_start,
    word_stream_if.dst    in,
    word_stream_if.src    out
);

    word_t sum_a;
    word_t sum_b;
    word_t a_base;
    word_t b_base;
    word_t a_next;
    word_t b_next;
    logic  tail_pend;

    // Addition modulo 65535, both operands below 2^16
    function automatic word_t add_mod(word_t x, word_t y);
        logic [WORD_W:0] s;
        s = x + y;
        if (s >= FLETCHER_MOD)
            s = s - FLETCHER_MOD;
        return s[WORD_W-1:0];
    endfunction

    // ============================================================
    // Running sums
    // ============================================================
    always_comb begin
        // First header word arrives together with capture_start
        a_base = capture_start ? '0 : sum_a;
        b_base = capture_start ? '0 : sum_b;
        a_next = add_mod(a_base, swap_bytes(in.data));
        b_next = add_mod(b_base, a_next);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (in.valid) begin
            sum_a <= a_next;
            sum_b <= b_next;
        end else if (capture_start) begin
            sum_a <= '0;
            sum_b <= '0;
        end
    end

    // ============================================================
    // Pass-through and trailer
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_pend  <= 1'b0;
            out.valid  <= 1'b0;
            out.sample <= 1'b0;
            out.eof    <= 1'b0;
        end else begin
            // Sum a goes out on the framer eof, sum b one cycle later
            tail_pend  <= in.eof;
            out.valid  <= in.valid || in.eof || tail_pend;
            out.sample <= in.valid && in.sample;
            out.eof    <= tail_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (in.eof)
            out.data <= swap_bytes(sum_a);
        else if (tail_pend)
            out.data <= swap_bytes(sum_b);
        else
            out.data <= in.data;
    end

endmodule

// File: design/capture_stats.sv
`timescale 1ns/1ps

module capture_stats import img_capture_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    capture_start,
    word_stream_if.dst              in,
    word_stream_if.src              out,
    output logic [WORD_COUNT_W-1:0] word_count,
    output logic [STAT_COUNT_W-1:0] highlight_count,
    output logic [STAT_COUNT_W-1:0] shadow_count,
    output logic                    capture_done
);

    logic                 vld_q;
    logic                 smp_q;
    logic                 eof_q;
    word_t                data_q;
    word_t                px_word;
    logic [STAT_BITS-1:0] px_top;

    // Pixel back from its little-endian word
    always_comb begin
        px_word = swap_bytes(in.data);
        px_top  = px_word[PIXEL_W-1 -: STAT_BITS];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q           <= 1'b0;
            smp_q           <= 1'b0;
            eof_q           <= 1'b0;
            capture_done    <= 1'b0;
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            vld_q        <= in.valid;
            smp_q        <= in.sample;
            eof_q        <= in.eof;
            capture_done <= eof_q;
            if (capture_start) begin
                word_count      <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end else if (in.valid) begin
                word_count <= word_count + 1'b1;
                if (in.sample) begin
                    if (&px_top)
                        highlight_count <= highlight_count + 1'b1;
                    else if (~|px_top)
                        shadow_count <= shadow_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= in.data;
    end

    assign out.valid  = vld_q;
    assign out.data   = data_q;
    assign out.sample = smp_q;
    assign out.eof    = eof_q;

endmodule

// File: design/word_fifo.sv
`timescale 1ns/1ps

module word_fifo import img_capture_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear,
    word_stream_if.dst    in,
    output logic          out_ready,
    input  logic          out_trigger,
    output word_t         out_data,
    output logic          overflow
);

    word_t                  mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0]  mem_count;
    logic                   full;
    logic                   push;
    logic                   drop;
    logic                   pop;
    logic                   load;

    // The output register counts toward the depth
    always_comb begin
        full = (mem_count + FIFO_CNT_W'(out_ready)) == FIFO_CNT_W'(FIFO_DEPTH);
        push = in.valid && !full;
        drop = in.valid && full;
        pop  = out_ready && out_trigger;
        load = (mem_count != '0) && (!out_ready || pop);
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in.data;
        if (load)
            out_data <= mem[rd_ptr];
    end

    // ============================================================
    // Pointers, head register and overflow
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            out_ready <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (load)
                rd_ptr <= rd_ptr + 1'b1;
            mem_count <= mem_count + FIFO_CNT_W'(push) - FIFO_CNT_W'(load);
            if (load)
                out_ready <= 1'b1;
            else if (pop)
                out_ready <= 1'b0;
            // Sticky until the next capture starts
            if (clear)
                overflow <= 1'b0;
            if (drop)
                overflow <= 1'b1;
        end
    end

endmodule

// File: design/img_capture_top.sv
`timescale 1ns/1ps

module img_capture_top import img_capture_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_capture,
    input  header_t                 cmd_header,
    input  pixel_t                  img_d,
    input  logic                    img_fv,
    input  logic                    img_lv,
    output logic                    out_ready,
    input  logic                    out_trigger,
    output word_t                   out_data,
    output logic                    capture_done,
    output logic [WORD_COUNT_W-1:0] word_count,
    output logic [STAT_COUNT_W-1:0] highlight_count,
    output logic [STAT_COUNT_W-1:0] shadow_count,
    output logic                    overflow
);

    logic capture_start;

    word_stream_if framed ();
    word_stream_if summed ();
    word_stream_if counted ();

    // ============================================================
    // Framer, trailer, stats, output FIFO
    // ============================================================
    pixel_framer u_framer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_capture   (cmd_capture),
        .cmd_header    (cmd_header),
        .img_d         (img_d),
        .img_fv        (img_fv),
        .img_lv        (img_lv),
        .capture_start (capture_start),
        .out           (framed.src)
    );

    fletcher_trailer u_trailer (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_start (capture_start),
        .in            (framed.dst),
        .out           (summed.src)
    );

    capture_stats u_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .capture_start   (capture_start),
        .in              (summed.dst),
        .out             (counted.src),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .capture_done    (capture_done)
    );

    // Old words keep draining across a new capture
    word_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (capture_start),
        .in          (counted.dst),
        .out_ready   (out_ready),
        .out_trigger (out_trigger),
        .out_data    (out_data),
        .overflow    (overflow)
    );

endmodule

// File: testbench/img_capture_assertions.sv
`timescale 1ns/1ps

module img_capture_assertions import img_capture_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  capture_done,
    input logic  out_ready,
    input logic  out_trigger,
    input word_t out_data
);

    // ============================================================
    // Completion pulse
    // ============================================================
    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        capture_done |=> !capture_done
    ) else $error("capture_done held high for two cycles");

    // ============================================================
    // Output handshake
    // ============================================================
    // FIFO comes out of reset empty
    ready_low_after_reset: assert property (
        @(posedge clk)
        !rst_n |=> !out_ready
    ) else $error("out_ready high in the cycle after reset");

    // Head word holds until the consumer takes it
    data_stable_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_ready && !out_trigger) |=> $stable(out_data)
    ) else $error("out_data changed while out_ready was high and out_trigger low");

endmodule

// File: testbench/img_capture_tb.sv
`timescale 1ns/1ps

module img_capture_tb import img_capture_pkg::*; ();

    // Longest test runs well under a thousand cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int HBLANK         = 3;
    localparam int VBLANK         = 8;

    logic                    clk;
    logic                    rst_n;
    logic                    cmd_capture;
    header_t                 cmd_header;
    pixel_t                  img_d;
    logic                    img_fv;
    logic                    img_lv;
    logic                    out_ready;
    logic                    out_trigger;
    word_t                   out_data;
    logic                    capture_done;
    logic [WORD_COUNT_W-1:0] word_count;
    logic [STAT_COUNT_W-1:0] highlight_count;
    logic [STAT_COUNT_W-1:0] shadow_count;
    logic                    overflow;

    word_t  rx_q[$];
    word_t  exp_q[$];
    pixel_t frame_px[$];
    int     frame_lines;
    int     frame_ppl;
    int     exp_wc;
    int     exp_hl;
    int     exp_sh;
    int     done_pulses;
    int     checks;
    int     errors;
    int     cycle_count;

    img_capture_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .out_ready       (out_ready),
        .out_trigger     (out_trigger),
        .out_data        (out_data),
        .capture_done    (capture_done),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .overflow        (overflow)
    );

    bind img_capture_top img_capture_assertions u_assertions (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_done (capture_done),
        .out_ready    (out_ready),
        .out_trigger  (out_trigger),
        .out_data     (out_data)
    );

    always #2 clk = ~clk;

    // Consumer side of the ready/trigger handshake
    always @(posedge clk) begin
        if (out_ready && out_trigger)
            rx_q.push_back(out_data);
        if (capture_done)
            done_pulses++;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Test FAILED");
        $finish;
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic check_stream(input string what);
        int i;
        check_value({what, " word total"}, rx_q.size(), exp_q.size());
        for (i = 0; i < rx_q.size() && i < exp_q.size(); i++)
            check_value($sformatf("%s word %0d", what, i), rx_q[i], exp_q[i]);
    endtask

    task automatic issue_capture(input header_t hdr);
        @(posedge clk);
        cmd_header  <= hdr;
        cmd_capture <= 1'b1;
        @(posedge clk);
        cmd_capture <= 1'b0;
    endtask

    // Sensor model drives vertical blanking and then lines framed by fv and lv
    task automatic drive_frame(input int lines, input int ppl, input bit extremes);
        pixel_t p;
        int     y;
        int     x;
        frame_px.delete();
        frame_lines = lines;
        frame_ppl   = ppl;
        repeat (VBLANK) @(posedge clk);
        img_fv <= 1'b1;
        for (y = 0; y < lines; y++) begin
            repeat (HBLANK) @(posedge clk);
            for (x = 0; x < ppl; x++) begin
                @(posedge clk);
                p = pixel_t'($urandom);
                if (extremes) begin
                    case ($urandom % 3)
                        0: p[PIXEL_W-1 -: STAT_BITS] = '1;
                        1: p[PIXEL_W-1 -: STAT_BITS] = '0;
                        default: ;
                    endcase
                end
                img_lv <= 1'b1;
                img_d  <= p;
                frame_px.push_back(p);
            end
            @(posedge clk);
            img_lv <= 1'b0;
            img_d  <= '0;
        end
        repeat (HBLANK) @(posedge clk);
        img_fv <= 1'b0;
        @(posedge clk);
    endtask

    // Reference model appends the expected words of one capture
    task automatic build_model(input header_t hdr);
        word_t  w;
        pixel_t p;
        int     a;
        int     b;
        int     i;
        int     y;
        int     x;
        a      = 0;
        b      = 0;
        exp_hl = 0;
        exp_sh = 0;
        for (i = 0; i < HEADER_WORDS + frame_lines * frame_ppl; i++) begin
            if (i < HEADER_WORDS) begin
                w = hdr[(HEADER_WORDS-1-i)*WORD_W +: WORD_W];
            end else begin
                y = (i - HEADER_WORDS) / frame_ppl;
                x = (i - HEADER_WORDS) % frame_ppl;
                p = frame_px[i - HEADER_WORDS];
                // Little-endian word of the zero-extended pixel
                w = {p[7:0], 4'h0, p[11:8]};
                if (x % (1 << SAMPLE_GRID_W) == 0 && y % (1 << SAMPLE_GRID_W) == 0) begin
                    if (p[PIXEL_W-1 -: STAT_BITS] == '1)
                        exp_hl++;
                    else if (p[PIXEL_W-1 -: STAT_BITS] == '0)
                        exp_sh++;
                end
            end
            exp_q.push_back(w);
            a = (a + {w[7:0], w[15:8]}) % 65535;
            b = (b + a) % 65535;
        end
        exp_q.push_back({a[7:0], a[15:8]});
        exp_q.push_back({b[7:0], b[15:8]});
        exp_wc = HEADER_WORDS + frame_lines * frame_ppl + 2;
    endtask

    task automatic wait_done();
        do
            @(posedge clk);
        while (!capture_done);
    endtask

    task automatic wait_words(input int n);
        while (rx_q.size() < n)
            @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    task automatic start_test(input bit trigger);
        rx_q.delete();
        exp_q.delete();
        done_pulses = 0;
        @(posedge clk);
        out_trigger <= trigger;
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_basic();
        header_t hdr;
        hdr = {$urandom, $urandom};
        start_test(1'b1);
        issue_capture(hdr);
        drive_frame(3, 5, 1'b0);
        wait_done();
        build_model(hdr);
        wait_words(exp_q.size());
        check_stream("basic");
        check_value("basic word_count", word_count, 21);
        check_value("basic capture_done pulses", done_pulses, 1);
    endtask

    task automatic test_stats();
        header_t hdr;
        hdr = {$urandom, $urandom};
        start_test(1'b1);
        issue_capture(hdr);
        drive_frame(8, 9, 1'b1);
        wait_done();
        build_model(hdr);
        wait_words(exp_q.size());
        check_stream("stats");
        check_value("stats word_count", word_count, exp_wc);
        check_value("stats highlight_count", highlight_count, exp_hl);
        check_value("stats shadow_count", shadow_count, exp_sh);
    endtask

    // Capture lands in the middle of a frame and only the next frame counts
    task automatic test_busy_frame();
        header_t hdr;
        hdr = {$urandom, $urandom};
        start_test(1'b1);
        fork
            drive_frame(4, 6, 1'b0);
            begin
                repeat (VBLANK + 2 * HBLANK + 4) @(posedge clk);
                issue_capture(hdr);
            end
        join
        drive_frame(2, 7, 1'b0);
        wait_done();
        build_model(hdr);
        wait_words(exp_q.size());
        check_stream("busy frame");
        check_value("busy frame word_count", word_count, exp_wc);
    endtask

    task automatic test_backpressure();
        header_t hdr;
        hdr = {$urandom, $urandom};
        start_test(1'b0);
        issue_capture(hdr);
        drive_frame(2, 6, 1'b0);
        wait_done();
        build_model(hdr);
        repeat (4) @(posedge clk);
        check_value("backpressure out_ready before trigger", out_ready, 1);
        out_trigger <= 1'b1;
        wait_words(exp_q.size());
        check_stream("backpressure");
        check_value("backpressure overflow", overflow, 0);
    endtask

    // Leaves the FIFO full for the next test to drain
    task automatic test_overflow();
        header_t hdr;
        hdr = {$urandom, $urandom};
        start_test(1'b0);
        issue_capture(hdr);
        drive_frame(4, 10, 1'b0);
        wait_done();
        build_model(hdr);
        while (exp_q.size() > FIFO_DEPTH)
            void'(exp_q.pop_back());
        repeat (4) @(posedge clk);
        check_value("overflow flag", overflow, 1);
        check_value("overflow out_ready before trigger", out_ready, 1);
    endtask

    task automatic test_second_capture();
        header_t hdr;
        hdr = {$urandom, $urandom};
        rx_q.delete();
        done_pulses = 0;
        @(posedge clk);
        out_trigger <= 1'b1;
        issue_capture(hdr);
        drive_frame(3, 7, 1'b1);
        wait_done();
        build_model(hdr);
        wait_words(exp_q.size());
        check_stream("second capture");
        check_value("second word_count", word_count, exp_wc);
        check_value("second highlight_count", highlight_count, exp_hl);
        check_value("second shadow_count", shadow_count, exp_sh);
        check_value("second overflow", overflow, 0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_capture = 1'b0;
        cmd_header  = '0;
        img_d       = '0;
        img_fv      = 1'b0;
        img_lv      = 1'b0;
        out_trigger = 1'b0;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        done_pulses = 0;
        void'($urandom(32'h1f89));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_basic();
        test_stats();
        test_busy_frame();
        test_backpressure();
        test_overflow();
        test_second_capture();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: img_capture.f
design/img_capture_pkg.sv
design/word_stream_if.sv
design/pixel_framer.sv
design/fletcher_trailer.sv
design/capture_stats.sv
design/word_fifo.sv
design/img_capture_top.sv
testbench/img_capture_assertions.sv
testbench/img_capture_tb.sv
